// ==== mem_bus_top.f ====
+incdir+rtl
rtl/mem_bus_pkg.sv
rtl/req_arbiter.sv
rtl/lane_align.sv
rtl/clint_timer.sv
rtl/mem_bus_top.sv
test/axi_mem_model.sv
test/mem_bus_tb.sv

// ==== rtl/clint_timer.sv ====
module clint_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rd_valid_i,
  input  logic                 hi_i,
  output mem_bus_pkg::rd_rsp_t rd_data_o,
  output logic                 rd_valid_o
);

  logic [63:0] mtime_q;
  logic [31:0] rd_data_q;
  logic        rd_valid_q;

  // mtime ticks once per clock from zero
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  // the half is sampled in the request cycle
  // so both words of one read pair are not coherent
  always_ff @(posedge clk)
  begin
    if (rd_valid_i)
    begin
      if (hi_i)
        rd_data_q <= mtime_q[63:32];
      else
        rd_data_q <= mtime_q[31:0];
    end
  end

  // response one cycle behind the request
  always_ff @(posedge clk)
  begin
    if (rst)
      rd_valid_q <= 1'b0;
    else
      rd_valid_q <= rd_valid_i;
  end

  assign rd_data_o.data = rd_data_q;
  assign rd_valid_o     = rd_valid_q;

endmodule

// ==== rtl/lane_align.sv ====
`include "mem_bus_config.svh"

module lane_align (
  input  mem_bus_pkg::rd_req_t  rd_req_i,
  input  mem_bus_pkg::wr_req_t  wr_req_i,
  input  mem_bus_pkg::beat_u    rd_beat_i,
  output mem_bus_pkg::axi_ar_t  ar_o,
  output mem_bus_pkg::axi_aw_t  aw_o,
  output mem_bus_pkg::axi_w_t   w_o,
  output mem_bus_pkg::rd_rsp_t  rd_data_o
);

  localparam int STRB_W = `MEM_BUS_DATA_W / 8;

  // byte offset inside the word, as a bit shift
  logic [4:0]                 rd_shift;
  logic [4:0]                 wr_shift;
  logic [`MEM_BUS_DATA_W-1:0] rd_word;
  logic [`MEM_BUS_DATA_W-1:0] wr_word;
  logic [STRB_W-1:0]          wr_strb;

  // transfer size from the byte strobe
  // byte, half, word; odd patterns fall back to a byte
  function automatic logic [2:0] size_of(input logic [STRB_W-1:0] strb);
    logic [2:0] size;
    case (strb)
      4'h1:    size = 3'd0;
      4'h3:    size = 3'd1;
      4'hf:    size = 3'd2;
      default: size = 3'd0;
    endcase
    return size;
  endfunction

  assign rd_shift = {rd_req_i.addr[1:0], 3'b000};
  assign wr_shift = {wr_req_i.addr[1:0], 3'b000};

  // read address, single incr beat, id zero
  always_comb
  begin
    ar_o.addr  = rd_req_i.addr;
    ar_o.size  = size_of(rd_req_i.strb);
    ar_o.len   = 8'd0;
    ar_o.burst = 2'b01;
    ar_o.id    = 4'd0;
  end

  // write address, same fixed fields
  always_comb
  begin
    aw_o.addr  = wr_req_i.addr;
    aw_o.size  = size_of(wr_req_i.strb);
    aw_o.len   = 8'd0;
    aw_o.burst = 2'b01;
    aw_o.id    = 4'd0;
  end

  // pick the half first, then drop the low bytes
  assign rd_word        = rd_beat_i.word[rd_req_i.addr[2]];
  assign rd_data_o.data = rd_word >> rd_shift;

  // store lanes move up by the offset
  // bytes pushed past the word are lost
  assign wr_word = wr_req_i.data << wr_shift;
  assign wr_strb = wr_req_i.strb << wr_req_i.addr[1:0];

  always_comb
  begin
    // same word in both halves, strobe picks the live one
    w_o.data.word[0] = wr_word;
    w_o.data.word[1] = wr_word;
    if (wr_req_i.addr[2])
      w_o.strb = {wr_strb, {STRB_W{1'b0}}};
    else
      w_o.strb = {{STRB_W{1'b0}}, wr_strb};
    w_o.last = 1'b1;
  end

endmodule

// ==== rtl/mem_bus_config.svh ====
`ifndef MEM_BUS_CONFIG_SVH
`define MEM_BUS_CONFIG_SVH

// byte address width seen by the core and on AXI
`define MEM_BUS_ADDR_W 32

// client word width, one load or store at most
`define MEM_BUS_DATA_W 32

// master beat width
// two client words per beat, picked by addr[2]
`define MEM_BUS_AXI_DATA_W 64

// clint mtime, low word
// 8-byte aligned, so the high word sits in the other half of the beat
`define MEM_BUS_MTIME_ADDR 32'h0200_bff8

// clint mtime, high word
`define MEM_BUS_MTIME_ADDR_HI (`MEM_BUS_MTIME_ADDR + 32'd4)

`endif

// ==== rtl/mem_bus_pkg.sv ====
`include "mem_bus_config.svh"

package mem_bus_pkg;

  // client read request, fetch and load share it
  typedef struct packed {
    logic [`MEM_BUS_ADDR_W-1:0]   addr;
    logic [`MEM_BUS_DATA_W/8-1:0] strb;
  } rd_req_t;

  // read data after lane alignment
  typedef struct packed {
    logic [`MEM_BUS_DATA_W-1:0] data;
  } rd_rsp_t;

  // store request, data still in the low lanes
  typedef struct packed {
    logic [`MEM_BUS_ADDR_W-1:0]   addr;
    logic [`MEM_BUS_DATA_W-1:0]   data;
    logic [`MEM_BUS_DATA_W/8-1:0] strb;
  } wr_req_t;

  // one beat, as a doubleword or as two words indexed by addr[2]
  typedef union packed {
    logic [`MEM_BUS_AXI_DATA_W-1:0]                                    dword;
    logic [`MEM_BUS_AXI_DATA_W/`MEM_BUS_DATA_W-1:0][`MEM_BUS_DATA_W-1:0] word;
  } beat_u;

  // read address channel
  typedef struct packed {
    logic [`MEM_BUS_ADDR_W-1:0] addr;
    logic [2:0]                 size;
    logic [7:0]                 len;
    logic [1:0]                 burst;
    logic [3:0]                 id;
  } axi_ar_t;

  // write address has the same fields
  typedef axi_ar_t axi_aw_t;

  typedef struct packed {
    beat_u                            data;
    logic [`MEM_BUS_AXI_DATA_W/8-1:0] strb;
    logic                             last;
  } axi_w_t;

  typedef struct packed {
    beat_u      data;
    logic [1:0] resp;
    logic       last;
    logic [3:0] id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic [3:0] id;
  } axi_b_t;

  // owner of the one outstanding transaction
  typedef enum logic [1:0] {
    CLIENT_NONE,
    CLIENT_FETCH,
    CLIENT_LOAD,
    CLIENT_STORE
  } client_e;

endpackage

// ==== rtl/mem_bus_top.sv ====
module mem_bus_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fetch_req_valid_i,
  input  mem_bus_pkg::rd_req_t fetch_req_i,
  output logic                 fetch_grant_o,
  output logic                 fetch_rsp_valid_o,
  output mem_bus_pkg::rd_rsp_t fetch_rsp_o,
  input  logic                 load_req_valid_i,
  input  mem_bus_pkg::rd_req_t load_req_i,
  output logic                 load_grant_o,
  output logic                 load_rsp_valid_o,
  output mem_bus_pkg::rd_rsp_t load_rsp_o,
  input  logic                 store_req_valid_i,
  input  mem_bus_pkg::wr_req_t store_req_i,
  output logic                 store_grant_o,
  output logic                 store_done_o,
  output mem_bus_pkg::axi_ar_t axi_ar_o,
  output logic                 axi_arvalid_o,
  input  logic                 axi_arready_i,
  input  mem_bus_pkg::axi_r_t  axi_r_i,
  input  logic                 axi_rvalid_i,
  output logic                 axi_rready_o,
  output mem_bus_pkg::axi_aw_t axi_aw_o,
  output logic                 axi_awvalid_o,
  input  logic                 axi_awready_i,
  output mem_bus_pkg::axi_w_t  axi_w_o,
  output logic                 axi_wvalid_o,
  input  logic                 axi_wready_i,
  input  mem_bus_pkg::axi_b_t  axi_b_i,
  input  logic                 axi_bvalid_i,
  output logic                 axi_bready_o
);
  import mem_bus_pkg::*;

  rd_req_t align_rd_req;
  wr_req_t align_wr_req;
  axi_ar_t align_ar;
  axi_aw_t align_aw;
  axi_w_t  align_w;
  rd_rsp_t align_rd_data;
  rd_rsp_t timer_data;
  logic    timer_rd_valid;
  logic    timer_hi;
  logic    timer_rsp_valid;

  req_arbiter u_arbiter (
    .clk               (clk),
    .rst               (rst),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_grant_o     (fetch_grant_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .load_req_valid_i  (load_req_valid_i),
    .load_req_i        (load_req_i),
    .load_grant_o      (load_grant_o),
    .load_rsp_valid_o  (load_rsp_valid_o),
    .store_req_valid_i (store_req_valid_i),
    .store_req_i       (store_req_i),
    .store_grant_o     (store_grant_o),
    .store_done_o      (store_done_o),
    .align_rd_req_o    (align_rd_req),
    .align_wr_req_o    (align_wr_req),
    .align_ar_i        (align_ar),
    .align_aw_i        (align_aw),
    .align_w_i         (align_w),
    .timer_rd_valid_o  (timer_rd_valid),
    .timer_hi_o        (timer_hi),
    .timer_rsp_valid_i (timer_rsp_valid),
    .axi_ar_o          (axi_ar_o),
    .axi_arvalid_o     (axi_arvalid_o),
    .axi_arready_i     (axi_arready_i),
    .axi_rvalid_i      (axi_rvalid_i),
    .axi_aw_o          (axi_aw_o),
    .axi_awvalid_o     (axi_awvalid_o),
    .axi_awready_i     (axi_awready_i),
    .axi_w_o           (axi_w_o),
    .axi_wvalid_o      (axi_wvalid_o),
    .axi_wready_i      (axi_wready_i),
    .axi_bvalid_i      (axi_bvalid_i)
  );

  lane_align u_align (
    .rd_req_i  (align_rd_req),
    .wr_req_i  (align_wr_req),
    .rd_beat_i (axi_r_i.data),
    .ar_o      (align_ar),
    .aw_o      (align_aw),
    .w_o       (align_w),
    .rd_data_o (align_rd_data)
  );

  clint_timer u_timer (
    .clk        (clk),
    .rst        (rst),
    .rd_valid_i (timer_rd_valid),
    .hi_i       (timer_hi),
    .rd_data_o  (timer_data),
    .rd_valid_o (timer_rsp_valid)
  );

  // fetch never reaches the timer
  assign fetch_rsp_o = align_rd_data;
  // timer answer wins in its response cycle
  assign load_rsp_o  = timer_rsp_valid ? timer_data : align_rd_data;

  // responses always accepted, resp and id are not checked
  assign axi_rready_o = 1'b1;
  assign axi_bready_o = 1'b1;

endmodule

// ==== rtl/req_arbiter.sv ====
`include "mem_bus_config.svh"

module req_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_req_valid_i,
  input  mem_bus_pkg::rd_req_t  fetch_req_i,
  output logic                  fetch_grant_o,
  output logic                  fetch_rsp_valid_o,
  input  logic                  load_req_valid_i,
  input  mem_bus_pkg::rd_req_t  load_req_i,
  output logic                  load_grant_o,
  output logic                  load_rsp_valid_o,
  input  logic                  store_req_valid_i,
  input  mem_bus_pkg::wr_req_t  store_req_i,
  output logic                  store_grant_o,
  output logic                  store_done_o,
  output mem_bus_pkg::rd_req_t  align_rd_req_o,
  output mem_bus_pkg::wr_req_t  align_wr_req_o,
  input  mem_bus_pkg::axi_ar_t  align_ar_i,
  input  mem_bus_pkg::axi_aw_t  align_aw_i,
  input  mem_bus_pkg::axi_w_t   align_w_i,
  output logic                  timer_rd_valid_o,
  output logic                  timer_hi_o,
  input  logic                  timer_rsp_valid_i,
  output mem_bus_pkg::axi_ar_t  axi_ar_o,
  output logic                  axi_arvalid_o,
  input  logic                  axi_arready_i,
  input  logic                  axi_rvalid_i,
  output mem_bus_pkg::axi_aw_t  axi_aw_o,
  output logic                  axi_awvalid_o,
  input  logic                  axi_awready_i,
  output mem_bus_pkg::axi_w_t   axi_w_o,
  output logic                  axi_wvalid_o,
  input  logic                  axi_wready_i,
  input  logic                  axi_bvalid_i
);
  import mem_bus_pkg::*;

  client_e owner_q;
  client_e pick;
  logic    grant_q;
  logic    timer_q;
  logic    timer_hi_q;
  rd_req_t rd_q;
  wr_req_t wr_q;
  logic    arvalid_q;
  logic    awvalid_q;
  logic    wvalid_q;
  logic    idle;
  logic    load_is_timer;
  logic    txn_done;

  // only load may address the clint
  assign load_is_timer = (load_req_i.addr == `MEM_BUS_MTIME_ADDR) ||
                         (load_req_i.addr == `MEM_BUS_MTIME_ADDR_HI);
  assign idle = (owner_q == CLIENT_NONE);

  // store first, then load over fetch
  always_comb
  begin
    if (store_req_valid_i)
      pick = CLIENT_STORE;
    else if (load_req_valid_i)
      pick = CLIENT_LOAD;
    else if (fetch_req_valid_i)
      pick = CLIENT_FETCH;
    else
      pick = CLIENT_NONE;
  end

  // owner held from accept until the response comes back
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner_q <= CLIENT_NONE;
      grant_q <= 1'b0;
      timer_q <= 1'b0;
    end
    else
    begin
      grant_q <= idle && (pick != CLIENT_NONE);
      if (idle && (pick != CLIENT_NONE))
      begin
        owner_q <= pick;
        timer_q <= (pick == CLIENT_LOAD) && load_is_timer;
      end
      else if (txn_done)
      begin
        owner_q <= CLIENT_NONE;
      end
    end
  end

  // request payload, frozen for the whole transaction
  always_ff @(posedge clk)
  begin
    if (idle && (pick == CLIENT_LOAD))
      rd_q <= load_req_i;
    else if (idle && (pick == CLIENT_FETCH))
      rd_q <= fetch_req_i;
    if (idle && (pick == CLIENT_STORE))
      wr_q <= store_req_i;
    if (idle)
      timer_hi_q <= (load_req_i.addr == `MEM_BUS_MTIME_ADDR_HI);
  end

  // channel valids rise the cycle after grant, each drops on its ready
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
    end
    else
    begin
      if (arvalid_q && axi_arready_i)
        arvalid_q <= 1'b0;
      else if (grant_q && !timer_q && (owner_q != CLIENT_STORE))
        arvalid_q <= 1'b1;
      // aw and w leave together but may be taken apart
      if (awvalid_q && axi_awready_i)
        awvalid_q <= 1'b0;
      else if (grant_q && (owner_q == CLIENT_STORE))
        awvalid_q <= 1'b1;
      if (wvalid_q && axi_wready_i)
        wvalid_q <= 1'b0;
      else if (grant_q && (owner_q == CLIENT_STORE))
        wvalid_q <= 1'b1;
    end
  end

  // grant is a one-cycle pulse to the new owner
  assign fetch_grant_o = grant_q && (owner_q == CLIENT_FETCH);
  assign load_grant_o  = grant_q && (owner_q == CLIENT_LOAD);
  assign store_grant_o = grant_q && (owner_q == CLIENT_STORE);

  // timer is read in the grant cycle, answers one cycle later
  assign timer_rd_valid_o = grant_q && timer_q;
  assign timer_hi_o       = timer_hi_q;

  // responses steered back by owner
  assign fetch_rsp_valid_o = (owner_q == CLIENT_FETCH) && axi_rvalid_i;
  assign load_rsp_valid_o  = (owner_q == CLIENT_LOAD) &&
                             (timer_q ? timer_rsp_valid_i : axi_rvalid_i);
  assign store_done_o      = (owner_q == CLIENT_STORE) && axi_bvalid_i;
  assign txn_done = fetch_rsp_valid_o || load_rsp_valid_o || store_done_o;

  assign align_rd_req_o = rd_q;
  assign align_wr_req_o = wr_q;
  assign axi_ar_o       = align_ar_i;
  assign axi_aw_o       = align_aw_i;
  assign axi_w_o        = align_w_i;
  assign axi_arvalid_o  = arvalid_q;
  assign axi_awvalid_o  = awvalid_q;
  assign axi_wvalid_o   = wvalid_q;

endmodule

// ==== test/axi_mem_model.sv ====
module axi_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  mem_bus_pkg::axi_ar_t ar_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output mem_bus_pkg::axi_r_t  r_o,
  output logic                 rvalid_o,
  input  mem_bus_pkg::axi_aw_t aw_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  mem_bus_pkg::axi_w_t  w_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output mem_bus_pkg::axi_b_t  b_o,
  output logic                 bvalid_o
);
  import mem_bus_pkg::*;

  // 2 KiB backing store, one doubleword per entry
  logic [63:0] mem [0:255];
  logic [63:0] rd_dword;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  axi_w_t      w_q;
  logic        rd_pend;
  logic        aw_got;
  logic        w_got;
  logic        b_pend;
  logic [1:0]  ar_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [1:0]  rd_wait;
  logic [1:0]  b_wait;
  int          i;
  int          k;

  // fill byte from the full 11-bit byte address
  function automatic logic [7:0] fill_byte(input logic [10:0] a);
    return a[7:0] ^ ({5'd0, a[10:8]} * 8'd37);
  endfunction

  initial
  begin
    arready_o = 1'b0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    rvalid_o  = 1'b0;
    bvalid_o  = 1'b0;
    rd_dword  = '0;
    for (i = 0; i < 2048; i++)
      mem[i / 8][(i % 8) * 8 +: 8] = fill_byte(i[10:0]);
  end

  // fixed response fields, okay and id zero
  assign r_o = {rd_dword, 2'b00, 1'b1, 4'd0};
  assign b_o = {2'b00, 4'd0};

  always @(posedge clk)
  begin
    if (rst)
    begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      rd_pend   <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
      ar_wait   <= 2'd0;
      aw_wait   <= 2'd0;
      w_wait    <= 2'd0;
    end
    else
    begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      // ready held off for a random count while valid waits
      if (arvalid_i && !arready_o)
      begin
        if (ar_wait == 2'd0)
          arready_o <= 1'b1;
        else
          ar_wait <= ar_wait - 2'd1;
      end
      if (arvalid_i && arready_o)
      begin
        arready_o <= 1'b0;
        ar_wait   <= 2'($urandom % 4);
        rd_pend   <= 1'b1;
        rd_addr   <= ar_i.addr;
        rd_wait   <= 2'($urandom % 4);
      end
      // single beat read after a random gap
      if (rd_pend)
      begin
        if (rd_wait == 2'd0)
        begin
          rvalid_o <= 1'b1;
          rd_dword <= mem[rd_addr[10:3]];
          rd_pend  <= 1'b0;
        end
        else
          rd_wait <= rd_wait - 2'd1;
      end
      if (awvalid_i && !awready_o)
      begin
        if (aw_wait == 2'd0)
          awready_o <= 1'b1;
        else
          aw_wait <= aw_wait - 2'd1;
      end
      if (awvalid_i && awready_o)
      begin
        awready_o <= 1'b0;
        aw_wait   <= 2'($urandom % 4);
        aw_got    <= 1'b1;
        wr_addr   <= aw_i.addr;
      end
      if (wvalid_i && !wready_o)
      begin
        if (w_wait == 2'd0)
          wready_o <= 1'b1;
        else
          w_wait <= w_wait - 2'd1;
      end
      if (wvalid_i && wready_o)
      begin
        wready_o <= 1'b0;
        w_wait   <= 2'($urandom % 4);
        w_got    <= 1'b1;
        w_q      <= w_i;
      end
      // both halves in, merge by strobe
      if (aw_got && w_got)
      begin
        for (k = 0; k < 8; k++)
          if (w_q.strb[k])
            mem[wr_addr[10:3]][k * 8 +: 8] <= w_q.data.dword[k * 8 +: 8];
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_pend <= 1'b1;
        b_wait <= 2'($urandom % 4);
      end
      if (b_pend)
      begin
        if (b_wait == 2'd0)
        begin
          bvalid_o <= 1'b1;
          b_pend   <= 1'b0;
        end
        else
          b_wait <= b_wait - 2'd1;
      end
    end
  end

endmodule

// ==== test/mem_bus_tb.sv ====
`include "mem_bus_config.svh"

module mem_bus_tb;
  import mem_bus_pkg::*;

  // fetch 8, load 12, store plus readback 32, priority 8, mtime 6
  localparam int N_OPS   = 66;
  localparam int TIMEOUT = N_OPS * 12 + 200;

  logic    clk;
  logic    rst;
  logic    fetch_req_valid;
  rd_req_t fetch_req;
  logic    fetch_grant;
  logic    fetch_rsp_valid;
  rd_rsp_t fetch_rsp;
  logic    load_req_valid;
  rd_req_t load_req;
  logic    load_grant;
  logic    load_rsp_valid;
  rd_rsp_t load_rsp;
  logic    store_req_valid;
  wr_req_t store_req;
  logic    store_grant;
  logic    store_done;
  axi_ar_t axi_ar;
  axi_ar_t ar_last;
  logic    arvalid;
  logic    arready;
  axi_r_t  axi_r;
  logic    rvalid;
  logic    rready;
  axi_aw_t axi_aw;
  axi_aw_t aw_last;
  logic    awvalid;
  logic    awready;
  axi_w_t  axi_w;
  axi_w_t  w_last;
  logic    wvalid;
  logic    wready;
  axi_b_t  axi_b;
  logic    bvalid;
  logic    bready;

  // expectations, driven by the stimulus ahead of each op
  string       test_name;
  logic [31:0] exp_addr;
  logic [2:0]  exp_size;
  logic [31:0] exp_rd;
  logic [7:0]  exp_wstrb;
  logic [63:0] exp_wdata;
  logic        timer_op;
  logic        timer_hi_op;
  logic [31:0] last_lo;
  logic        got_grant;
  logic        ar_open;
  int          val_errs;
  int          proto_errs;
  int          cycles;
  logic [7:0]  ref_mem [0:2047];

  mem_bus_top u_dut (
    .clk (clk), .rst (rst),
    .fetch_req_valid_i (fetch_req_valid), .fetch_req_i (fetch_req),
    .fetch_grant_o (fetch_grant), .fetch_rsp_valid_o (fetch_rsp_valid),
    .fetch_rsp_o (fetch_rsp),
    .load_req_valid_i (load_req_valid), .load_req_i (load_req),
    .load_grant_o (load_grant), .load_rsp_valid_o (load_rsp_valid),
    .load_rsp_o (load_rsp),
    .store_req_valid_i (store_req_valid), .store_req_i (store_req),
    .store_grant_o (store_grant), .store_done_o (store_done),
    .axi_ar_o (axi_ar), .axi_arvalid_o (arvalid), .axi_arready_i (arready),
    .axi_r_i (axi_r), .axi_rvalid_i (rvalid), .axi_rready_o (rready),
    .axi_aw_o (axi_aw), .axi_awvalid_o (awvalid), .axi_awready_i (awready),
    .axi_w_o (axi_w), .axi_wvalid_o (wvalid), .axi_wready_i (wready),
    .axi_b_i (axi_b), .axi_bvalid_i (bvalid), .axi_bready_o (bready)
  );

  axi_mem_model u_mem (
    .clk (clk), .rst (rst),
    .ar_i (axi_ar), .arvalid_i (arvalid), .arready_o (arready),
    .r_o (axi_r), .rvalid_o (rvalid),
    .aw_i (axi_aw), .awvalid_i (awvalid), .awready_o (awready),
    .w_i (axi_w), .wvalid_i (wvalid), .wready_o (wready),
    .b_o (axi_b), .bvalid_o (bvalid)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [7:0] fill_byte(input logic [10:0] a);
    return a[7:0] ^ ({5'd0, a[10:8]} * 8'd37);
  endfunction

  // byte, half, word; anything else counts as a byte
  function automatic logic [2:0] size_for(input logic [3:0] strb);
    if (strb == 4'h3)
      return 3'd1;
    else if (strb == 4'hf)
      return 3'd2;
    return 3'd0;
  endfunction

  // word at addr & ~3, dropped by the byte offset
  function automatic logic [31:0] read_expect(input logic [31:0] addr);
    logic [10:0] base;
    logic [31:0] word;
    base = {addr[10:2], 2'b00};
    word = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
    return word >> (8 * addr[1:0]);
  endfunction

  // monitors for the grant and single outstanding read
  always @(posedge clk)
  begin
    ar_last <= axi_ar;
    aw_last <= axi_aw;
    w_last  <= axi_w;
    if (fetch_grant || load_grant || store_grant)
      got_grant <= 1'b1;
    if (rst || rvalid)
      ar_open <= 1'b0;
    else if (arvalid && arready)
      ar_open <= 1'b1;
  end

  initial
  begin
    cycles = 0;
    forever
    begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT)
      begin
        $display("Timeout: a handshake never finished within %0d cycles", TIMEOUT);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

  // valid held with frozen fields until ready
  assert property (@(posedge clk) disable iff (rst)
    arvalid && !arready |=> arvalid && axi_ar == ar_last)
  else begin proto_errs++; $display("%s: arvalid or ar fields changed before arready", test_name); end
  assert property (@(posedge clk) disable iff (rst)
    awvalid && !awready |=> awvalid && axi_aw == aw_last)
  else begin proto_errs++; $display("%s: awvalid or aw fields changed before awready", test_name); end
  assert property (@(posedge clk) disable iff (rst)
    wvalid && !wready |=> wvalid && axi_w == w_last)
  else begin proto_errs++; $display("%s: wvalid or w fields changed before wready", test_name); end
  // no grant while a channel is busy
  assert property (@(posedge clk) disable iff (rst)
    (arvalid || awvalid || wvalid) |-> !(fetch_grant || load_grant || store_grant))
  else begin proto_errs++; $display("%s: grant given while the bus was busy", test_name); end
  assert property (@(posedge clk) disable iff (rst) ar_open |-> !arvalid)
  else begin proto_errs++; $display("%s: second read address before the read data", test_name); end
  assert property (@(posedge clk) disable iff (rst) fetch_grant |-> !load_req_valid)
  else begin proto_errs++; $display("%s: fetch granted ahead of a pending load", test_name); end
  assert property (@(posedge clk) disable iff (rst)
    (fetch_rsp_valid || load_rsp_valid) |-> got_grant)
  else begin proto_errs++; $display("%s: response came without a grant", test_name); end
  assert property (@(posedge clk) disable iff (rst) store_done == bvalid)
  else begin proto_errs++; $display("%s: store done and bvalid disagree", test_name); end
  // responses always taken
  assert property (@(posedge clk) disable iff (rst) rready && bready)
  else begin proto_errs++; $display("%s: rready or bready was not held high", test_name); end
  // mtime loads stay local and answer two cycles after the request
  assert property (@(posedge clk) disable iff (rst) timer_op |-> !arvalid)
  else begin proto_errs++; $display("%s: mtime load reached the read channel", test_name); end
  assert property (@(posedge clk) disable iff (rst)
    $rose(load_req_valid) && timer_op |-> !load_rsp_valid ##1 !load_rsp_valid ##1 load_rsp_valid)
  else begin proto_errs++; $display("%s: mtime response not two cycles after request", test_name); end

  // value checks
  assert property (@(posedge clk) disable iff (rst) arvalid |-> axi_ar.addr == exp_addr)
  else begin val_errs++; $display("Error %s: araddr expected %h actual %h",
    test_name, exp_addr, $sampled(axi_ar.addr)); end
  assert property (@(posedge clk) disable iff (rst) arvalid |-> axi_ar.size == exp_size)
  else begin val_errs++; $display("Error %s: arsize expected %0d actual %0d",
    test_name, exp_size, $sampled(axi_ar.size)); end
  // single incr beat, id zero
  assert property (@(posedge clk) disable iff (rst)
    arvalid |-> axi_ar.len == 8'd0 && axi_ar.burst == 2'b01 && axi_ar.id == 4'd0)
  else begin val_errs++; $display("Error %s: arlen/burst/id expected 0/1/0 actual %0d/%0d/%0d",
    test_name, $sampled(axi_ar.len), $sampled(axi_ar.burst), $sampled(axi_ar.id)); end
  assert property (@(posedge clk) disable iff (rst) awvalid |-> axi_aw.addr == exp_addr)
  else begin val_errs++; $display("Error %s: awaddr expected %h actual %h",
    test_name, exp_addr, $sampled(axi_aw.addr)); end
  assert property (@(posedge clk) disable iff (rst) awvalid |-> axi_aw.size == exp_size)
  else begin val_errs++; $display("Error %s: awsize expected %0d actual %0d",
    test_name, exp_size, $sampled(axi_aw.size)); end
  assert property (@(posedge clk) disable iff (rst)
    awvalid |-> axi_aw.len == 8'd0 && axi_aw.burst == 2'b01 && axi_aw.id == 4'd0)
  else begin val_errs++; $display("Error %s: awlen/burst/id expected 0/1/0 actual %0d/%0d/%0d",
    test_name, $sampled(axi_aw.len), $sampled(axi_aw.burst), $sampled(axi_aw.id)); end
  assert property (@(posedge clk) disable iff (rst) wvalid |-> axi_w.strb == exp_wstrb)
  else begin val_errs++; $display("Error %s: wstrb expected %h actual %h",
    test_name, exp_wstrb, $sampled(axi_w.strb)); end
  assert property (@(posedge clk) disable iff (rst) wvalid |-> axi_w.data.dword == exp_wdata)
  else begin val_errs++; $display("Error %s: wdata expected %h actual %h",
    test_name, exp_wdata, $sampled(axi_w.data.dword)); end
  assert property (@(posedge clk) disable iff (rst) wvalid |-> axi_w.last)
  else begin val_errs++; $display("Error %s: wlast expected 1 actual %0d",
    test_name, $sampled(axi_w.last)); end
  assert property (@(posedge clk) disable iff (rst) fetch_rsp_valid |-> fetch_rsp.data == exp_rd)
  else begin val_errs++; $display("Error %s: fetch data expected %h actual %h",
    test_name, exp_rd, $sampled(fetch_rsp.data)); end
  assert property (@(posedge clk) disable iff (rst)
    load_rsp_valid && !timer_op |-> load_rsp.data == exp_rd)
  else begin val_errs++; $display("Error %s: load data expected %h actual %h",
    test_name, exp_rd, $sampled(load_rsp.data)); end
  assert property (@(posedge clk) disable iff (rst)
    load_rsp_valid && timer_op && timer_hi_op |-> load_rsp.data == 32'd0)
  else begin val_errs++; $display("Error %s: mtime high expected %h actual %h",
    test_name, 32'd0, $sampled(load_rsp.data)); end
  assert property (@(posedge clk) disable iff (rst)
    load_rsp_valid && timer_op && !timer_hi_op |-> load_rsp.data > last_lo)
  else begin val_errs++; $display("Error %s: mtime low expected above %h actual %h",
    test_name, last_lo, $sampled(load_rsp.data)); end

  task automatic wait_grant(input int port);
    do
    begin
      @(posedge clk);
      #1;
    end
    while (!((port == 0 && fetch_grant) || (port == 1 && load_grant) ||
             (port == 2 && store_grant)));
    if (port == 0)
      fetch_req_valid = 1'b0;
    else if (port == 1)
      load_req_valid = 1'b0;
    else
      store_req_valid = 1'b0;
  endtask

  // response, then one idle cycle so the next request meets an idle bus
  task automatic wait_rsp(input int port);
    while (!((port == 0 && fetch_rsp_valid) || (port == 1 && load_rsp_valid) ||
             (port == 2 && store_done)))
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic do_read(input int port, input logic [31:0] addr, input logic [3:0] strb);
    exp_addr  = addr;
    exp_size  = size_for(strb);
    exp_rd    = read_expect(addr);
    got_grant = 1'b0;
    if (port == 1)
    begin
      load_req.addr  = addr;
      load_req.strb  = strb;
      load_req_valid = 1'b1;
    end
    else
    begin
      fetch_req.addr  = addr;
      fetch_req.strb  = strb;
      fetch_req_valid = 1'b1;
    end
    wait_grant(port);
    wait_rsp(port);
  endtask

  task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    logic [3:0]  lanes;
    logic [31:0] moved;
    lanes     = strb << addr[1:0];
    moved     = data << (8 * addr[1:0]);
    exp_addr  = addr;
    exp_size  = size_for(strb);
    exp_wstrb = addr[2] ? {lanes, 4'h0} : {4'h0, lanes};
    exp_wdata = {moved, moved};
    got_grant = 1'b0;
    store_req.addr  = addr;
    store_req.data  = data;
    store_req.strb  = strb;
    store_req_valid = 1'b1;
    wait_grant(2);
    wait_rsp(2);
    for (int i = 0; i < 4; i++)
      if (lanes[i])
        ref_mem[{addr[10:2], 2'b00} + i] = moved[i * 8 +: 8];
  endtask

  task automatic read_mtime(input logic hi);
    logic [31:0] seen;
    timer_op       = 1'b1;
    timer_hi_op    = hi;
    got_grant      = 1'b0;
    load_req.addr  = hi ? `MEM_BUS_MTIME_ADDR_HI : `MEM_BUS_MTIME_ADDR;
    load_req.strb  = 4'hf;
    load_req_valid = 1'b1;
    wait_grant(1);
    while (!load_rsp_valid)
    begin
      @(posedge clk);
      #1;
    end
    seen = load_rsp.data;
    @(posedge clk);
    #1;
    // previous low word moves on once this response was checked
    if (!hi)
      last_lo = seen;
    timer_op = 1'b0;
  endtask

  // load and fetch raised together, load must go first
  task automatic race_pair(input logic [31:0] l_addr, input logic [31:0] f_addr);
    exp_addr  = l_addr;
    exp_size  = 3'd2;
    exp_rd    = read_expect(l_addr);
    got_grant = 1'b0;
    load_req.addr   = l_addr;
    load_req.strb   = 4'hf;
    fetch_req.addr  = f_addr;
    fetch_req.strb  = 4'hf;
    load_req_valid  = 1'b1;
    fetch_req_valid = 1'b1;
    wait_grant(1);
    while (!load_rsp_valid)
    begin
      @(posedge clk);
      #1;
    end
    // load response sampled before the fetch expectations take over
    @(posedge clk);
    #1;
    exp_addr  = f_addr;
    exp_rd    = read_expect(f_addr);
    got_grant = 1'b0;
    wait_grant(0);
    wait_rsp(0);
  endtask

  initial
  begin
    logic [3:0]  strb_set [3];
    logic [31:0] addr;
    void'($urandom(32'h8628a3c1));
    strb_set = '{4'h1, 4'h3, 4'hf};
    rst = 1'b1;
    fetch_req_valid = 1'b0;
    fetch_req = '0;
    load_req_valid = 1'b0;
    load_req = '0;
    store_req_valid = 1'b0;
    store_req = '0;
    test_name = "reset";
    exp_addr = '0;
    exp_size = '0;
    exp_rd = '0;
    exp_wstrb = '0;
    exp_wdata = '0;
    timer_op = 1'b0;
    timer_hi_op = 1'b0;
    last_lo = '0;
    got_grant = 1'b0;
    val_errs = 0;
    proto_errs = 0;
    for (int i = 0; i < 2048; i++)
      ref_mem[i] = fill_byte(i[10:0]);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "fetch";
    repeat (8)
      do_read(0, $urandom & 32'h7fc, 4'hf);

    test_name = "load_align";
    for (int off = 0; off < 4; off++)
      for (int s = 0; s < 3; s++)
        do_read(1, ($urandom & 32'h7fc) | off, strb_set[s]);

    test_name = "store";
    repeat (16)
    begin
      addr = $urandom & 32'h7ff;
      do_store(addr, $urandom, 4'($urandom));
      do_read(1, addr & 32'h7fc, 4'hf);
    end

    test_name = "priority";
    repeat (4)
      race_pair($urandom & 32'h7fc, $urandom & 32'h7fc);

    test_name = "mtime";
    repeat (3)
    begin
      read_mtime(1'b0);
      read_mtime(1'b1);
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
